// File: source/ecc_intc_macros.svh
// Counts and widths of the ECC memory interconnect
// Initiators, banks, data and codeword sizes, address split, counter size

`ifndef ECC_INTC_MACROS_SVH
`define ECC_INTC_MACROS_SVH

`define ECC_N_INIT  4   // Initiator ports
`define ECC_N_MEM   4   // Interleaved memory banks

`define ECC_DATA_W  32  // Payload word
`define ECC_PAR_W   7   // 6 Hamming bits plus overall parity
`define ECC_CODE_W  39  // Stored SECDED codeword

`define ECC_ADDR_W  12  // Initiator word address
`define ECC_ROW_W   10  // Row inside one bank

`define ECC_CNT_W   16  // Saturating error counters

`endif

// File: source/ecc_intc_pkg.sv
// Packed struct types of the ECC memory interconnect
// Initiator request and response, crossbar to bank port traffic,
// memory bank request and read codeword, error pulses, register access

`include "ecc_intc_macros.svh"

package ecc_intc_pkg;

  typedef struct packed {
    logic                   req;
    logic                   wen;    // 1 is read, 0 is write
    logic [`ECC_ADDR_W-1:0] addr;   // Word address, bank in low bits
    logic [`ECC_DATA_W-1:0] wdata;
  } init_req_t;

  typedef struct packed {
    logic                   gnt;    // Combinational grant
    logic                   r_valid;
    logic [`ECC_DATA_W-1:0] r_data;
  } init_rsp_t;

  typedef struct packed {
    logic                   req;
    logic                   wen;
    logic [`ECC_ROW_W-1:0]  row;
    logic [`ECC_DATA_W-1:0] wdata;
  } bank_req_t;

  typedef struct packed {
    logic                   r_valid;
    logic [`ECC_DATA_W-1:0] r_data;  // Corrected data
  } bank_rsp_t;

  typedef struct packed {
    logic                   req;
    logic                   we;     // Write strobe
    logic [`ECC_ROW_W-1:0]  row;
    logic [`ECC_CODE_W-1:0] wcode;
  } mem_req_t;

  typedef struct packed {
    logic [`ECC_CODE_W-1:0] rcode;  // Valid the cycle after a read
  } mem_rsp_t;

  typedef struct packed {
    logic corr;
    logic uncorr;
  } ecc_err_t;

  typedef struct packed {
    logic valid;
    logic write;  // Write clears the counter
    logic sel;    // 0 correctable, 1 uncorrectable
  } reg_req_t;

  typedef struct packed {
    logic                  valid;
    logic [`ECC_CNT_W-1:0] rdata;
  } reg_rsp_t;

endpackage

// File: source/bank_xbar.sv
// Crossbar between initiators and interleaved memory banks
// Bank decode on the low word address bits
// Per-bank round-robin arbiter with registered winner index
// Read response routing back to the winning initiator

`timescale 1ns/100ps
`include "ecc_intc_macros.svh"

module bank_xbar (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  ecc_intc_pkg::init_req_t [`ECC_N_INIT-1:0] init_req_i,
  output ecc_intc_pkg::init_rsp_t [`ECC_N_INIT-1:0] init_rsp_o,
  output ecc_intc_pkg::bank_req_t [`ECC_N_MEM-1:0]  bank_req_o,
  input  ecc_intc_pkg::bank_rsp_t [`ECC_N_MEM-1:0]  bank_rsp_i
);

  localparam int unsigned IDX_W  = $clog2(`ECC_N_INIT);
  localparam int unsigned BANK_W = $clog2(`ECC_N_MEM);

  logic [`ECC_N_MEM-1:0][`ECC_N_INIT-1:0] hit;       // Bank b targeted by initiator i
  logic [`ECC_N_MEM-1:0][`ECC_N_INIT-1:0] gnt_m;     // One-hot grant per bank
  logic [`ECC_N_MEM-1:0]                  bank_any;  // Some requester won
  logic [`ECC_N_MEM-1:0][IDX_W-1:0]       win_d;     // Winner this cycle
  logic [`ECC_N_MEM-1:0][IDX_W-1:0]       win_q;     // Winner of last grant
  logic [`ECC_N_MEM-1:0][IDX_W-1:0]       rr_q;      // First in priority order

  always_comb begin : proc_decode
    for (int b = 0; b < `ECC_N_MEM; b++) begin
      for (int i = 0; i < `ECC_N_INIT; i++) begin
        hit[b][i] = init_req_i[i].req &&
                    (init_req_i[i].addr[BANK_W-1:0] == BANK_W'(b));
      end
    end
  end

  // Scan from the pointer upward, lowest offset wins
  always_comb begin : proc_arbitrate
    logic [IDX_W-1:0] idx;
    idx      = '0;
    gnt_m    = '0;
    bank_any = '0;
    win_d    = rr_q;
    for (int b = 0; b < `ECC_N_MEM; b++) begin
      for (int k = `ECC_N_INIT - 1; k >= 0; k--) begin
        idx = rr_q[b] + IDX_W'(k);  // Wraps around
        if (hit[b][idx]) begin
          win_d[b]    = idx;
          bank_any[b] = 1'b1;
        end
      end
      if (bank_any[b]) begin
        gnt_m[b][win_d[b]] = 1'b1;
      end
    end
  end

  always_comb begin : proc_bank_req
    for (int b = 0; b < `ECC_N_MEM; b++) begin
      bank_req_o[b].req   = bank_any[b];
      bank_req_o[b].wen   = init_req_i[win_d[b]].wen;
      bank_req_o[b].row   = init_req_i[win_d[b]].addr[`ECC_ADDR_W-1:BANK_W];
      bank_req_o[b].wdata = init_req_i[win_d[b]].wdata;
    end
  end

  // Grant now, read data one cycle later via win_q
  always_comb begin : proc_rsp_route
    init_rsp_o = '0;
    for (int i = 0; i < `ECC_N_INIT; i++) begin
      for (int b = 0; b < `ECC_N_MEM; b++) begin
        init_rsp_o[i].gnt = init_rsp_o[i].gnt | gnt_m[b][i];
        if (bank_rsp_i[b].r_valid && (win_q[b] == IDX_W'(i))) begin
          init_rsp_o[i].r_valid = 1'b1;
          init_rsp_o[i].r_data  = bank_rsp_i[b].r_data;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_rr
    if (!rst_ni) begin
      rr_q  <= '0;
      win_q <= '0;
    end else begin
      for (int b = 0; b < `ECC_N_MEM; b++) begin
        if (bank_any[b]) begin  // Pointer moves only on a grant
          rr_q[b]  <= win_d[b] + 1'b1;
          win_q[b] <= win_d[b];
        end
      end
    end
  end

  for (genvar b = 0; b < `ECC_N_MEM; b++) begin : gen_bank_chk
    a_one_gnt : assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(gnt_m[b]))
      else $error("Bank %0d granted more than one initiator", b);
  end

  for (genvar i = 0; i < `ECC_N_INIT; i++) begin : gen_init_chk
    a_gnt_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
      init_rsp_o[i].gnt |-> init_req_i[i].req)
      else $error("Initiator %0d granted without a request", i);
  end

endmodule

// File: source/secded_bank_port.sv
// SECDED bank port between crossbar and one memory bank
// Hamming encoder on writes, syndrome decode and single-bit fix on reads
// Codeword bit k holds Hamming position k+1, check bits at powers of two,
// top bit is even parity over the other 38

`timescale 1ns/100ps
`include "ecc_intc_macros.svh"

module secded_bank_port (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  ecc_intc_pkg::bank_req_t bank_req_i,
  output ecc_intc_pkg::bank_rsp_t bank_rsp_o,
  output ecc_intc_pkg::mem_req_t  mem_req_o,
  input  ecc_intc_pkg::mem_rsp_t  mem_rsp_i,
  output ecc_intc_pkg::ecc_err_t  err_o
);

  localparam int unsigned HAM_W = `ECC_CODE_W - 1;  // Positions 1 to 38
  localparam int unsigned SYN_W = `ECC_PAR_W - 1;   // Hamming check bits

  logic             rd_issued_q;  // Read sent to memory last cycle
  logic [SYN_W-1:0] syndrome;
  logic             par_err;      // Overall parity mismatch
  logic             single_err;
  logic             double_err;
  logic [HAM_W-1:0] fixed;        // Hamming part after correction

  // Data bits go to non power-of-two positions, in order
  function automatic logic [HAM_W-1:0] ham_fill(input logic [`ECC_DATA_W-1:0] data);
    logic [HAM_W-1:0] ham;
    int unsigned      d;
    ham = '0;
    d   = 0;
    for (int unsigned pos = 1; pos <= HAM_W; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        ham[pos-1] = data[d];
        d++;
      end
    end
    return ham;
  endfunction

  function automatic logic [`ECC_DATA_W-1:0] ham_extract(input logic [HAM_W-1:0] ham);
    logic [`ECC_DATA_W-1:0] data;
    int unsigned            d;
    data = '0;
    d    = 0;
    for (int unsigned pos = 1; pos <= HAM_W; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        data[d] = ham[pos-1];
        d++;
      end
    end
    return data;
  endfunction

  // Bit p covers every position with bit p set
  function automatic logic [SYN_W-1:0] ham_syndrome(input logic [HAM_W-1:0] ham);
    logic [SYN_W-1:0] syn;
    syn = '0;
    for (int unsigned pos = 1; pos <= HAM_W; pos++) begin
      for (int unsigned p = 0; p < SYN_W; p++) begin
        if (((pos >> p) & 1) != 0) begin
          syn[p] = syn[p] ^ ham[pos-1];
        end
      end
    end
    return syn;
  endfunction

  function automatic logic [`ECC_CODE_W-1:0] secded_enc(input logic [`ECC_DATA_W-1:0] data);
    logic [HAM_W-1:0] ham;
    logic [SYN_W-1:0] chk;
    ham = ham_fill(data);
    chk = ham_syndrome(ham);  // Check slots still zero here
    for (int unsigned p = 0; p < SYN_W; p++) begin
      ham[(1 << p) - 1] = chk[p];
    end
    return {^ham, ham};
  endfunction

  assign mem_req_o.req   = bank_req_i.req;
  assign mem_req_o.we    = bank_req_i.req && !bank_req_i.wen;
  assign mem_req_o.row   = bank_req_i.row;
  assign mem_req_o.wcode = secded_enc(bank_req_i.wdata);

  always_comb begin : proc_decode
    syndrome   = ham_syndrome(mem_rsp_i.rcode[HAM_W-1:0]);
    par_err    = ^mem_rsp_i.rcode;
    single_err = par_err && (syndrome <= SYN_W'(HAM_W));  // Zero means parity bit hit
    double_err = !single_err && (syndrome != '0);
    fixed      = mem_rsp_i.rcode[HAM_W-1:0];
    if (single_err && (syndrome != '0)) begin
      fixed[syndrome-1] = !fixed[syndrome-1];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_rd_issued
    if (!rst_ni) begin
      rd_issued_q <= 1'b0;
    end else begin
      rd_issued_q <= bank_req_i.req && bank_req_i.wen;
    end
  end

  assign bank_rsp_o.r_valid = rd_issued_q;
  assign bank_rsp_o.r_data  = ham_extract(fixed);  // Raw bits on double error
  assign err_o.corr         = rd_issued_q && single_err;
  assign err_o.uncorr       = rd_issued_q && double_err;

  // Returned word re-encodes to within one bit of the stored codeword
  a_err_excl : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bank_rsp_o.r_valid && !err_o.uncorr) |->
      ($countones(secded_enc(bank_rsp_o.r_data) ^ mem_rsp_i.rcode) <= 1))
    else $error("Read data not within one bit of the stored codeword");

endmodule

// File: source/ecc_err_counters.sv
// Saturating counters of correctable and uncorrectable read errors
// Sums error pulses of all banks each cycle
// Register port with registered reads and clear on write

`timescale 1ns/100ps
`include "ecc_intc_macros.svh"

module ecc_err_counters (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  ecc_intc_pkg::ecc_err_t [`ECC_N_MEM-1:0] err_i,
  input  ecc_intc_pkg::reg_req_t                  reg_req_i,
  output ecc_intc_pkg::reg_rsp_t                  reg_rsp_o
);

  localparam int unsigned INC_W = $clog2(`ECC_N_MEM + 1);
  localparam int unsigned SUM_W = `ECC_CNT_W + 1;  // Carry out flags overflow

  logic [1:0][`ECC_N_MEM-1:0] hits;   // Index 0 correctable, 1 uncorrectable
  logic [1:0][INC_W-1:0]      inc;
  logic [1:0][SUM_W-1:0]      sum;
  logic [1:0]                 clr;
  logic [1:0][`ECC_CNT_W-1:0] cnt_q;
  logic                       rd_req;
  logic                       rsp_valid_q;
  logic [`ECC_CNT_W-1:0]      rdata_q;

  assign rd_req = reg_req_i.valid && !reg_req_i.write;

  always_comb begin : proc_sum
    for (int b = 0; b < `ECC_N_MEM; b++) begin
      hits[0][b] = err_i[b].corr;
      hits[1][b] = err_i[b].uncorr;
    end
    for (int k = 0; k < 2; k++) begin
      inc[k] = INC_W'($countones(hits[k]));
      sum[k] = {1'b0, cnt_q[k]} + SUM_W'(inc[k]);
      clr[k] = reg_req_i.valid && reg_req_i.write && (reg_req_i.sel == 1'(k));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_cnt
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      for (int k = 0; k < 2; k++) begin
        if (clr[k]) begin           // Clear wins over increments
          cnt_q[k] <= '0;
        end else if (sum[k][SUM_W-1]) begin
          cnt_q[k] <= '1;           // Saturate
        end else begin
          cnt_q[k] <= sum[k][`ECC_CNT_W-1:0];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_rsp_valid
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= rd_req;  // Writes get no answer
    end
  end

  always_ff @(posedge clk_i) begin : proc_rsp_data
    if (rd_req) begin
      rdata_q <= cnt_q[reg_req_i.sel];
    end
  end

  assign reg_rsp_o.valid = rsp_valid_q;
  assign reg_rsp_o.rdata = rdata_q;

  // Without a clear a counter never goes down, also not past saturation
  for (genvar k = 0; k < 2; k++) begin : gen_cnt_chk
    a_cnt_mono : assert property (@(posedge clk_i) disable iff (!rst_ni)
      !$past(clr[k]) |-> (cnt_q[k] >= $past(cnt_q[k])))
      else $error("Error counter %0d decreased without a clear", k);
  end

endmodule

// File: source/ecc_intc_top.sv
// Top level of the ECC protected memory interconnect
// Crossbar, one SECDED port per bank, error counters

`timescale 1ns/100ps
`include "ecc_intc_macros.svh"

module ecc_intc_top (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  ecc_intc_pkg::init_req_t [`ECC_N_INIT-1:0] init_req_i,
  output ecc_intc_pkg::init_rsp_t [`ECC_N_INIT-1:0] init_rsp_o,
  output ecc_intc_pkg::mem_req_t  [`ECC_N_MEM-1:0]  mem_req_o,
  input  ecc_intc_pkg::mem_rsp_t  [`ECC_N_MEM-1:0]  mem_rsp_i,
  input  ecc_intc_pkg::reg_req_t                    reg_req_i,
  output ecc_intc_pkg::reg_rsp_t                    reg_rsp_o
);

  import ecc_intc_pkg::*;

  bank_req_t [`ECC_N_MEM-1:0] bank_req;  // Plain words toward the banks
  bank_rsp_t [`ECC_N_MEM-1:0] bank_rsp;  // Decoded read data
  ecc_err_t  [`ECC_N_MEM-1:0] bank_err;  // Per-bank error pulses

  bank_xbar i_bank_xbar (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .init_req_i ( init_req_i ),
    .init_rsp_o ( init_rsp_o ),
    .bank_req_o ( bank_req   ),
    .bank_rsp_i ( bank_rsp   )
  );

  for (genvar b = 0; b < `ECC_N_MEM; b++) begin : gen_bank_port
    secded_bank_port i_secded_bank_port (
      .clk_i      ( clk_i        ),
      .rst_ni     ( rst_ni       ),
      .bank_req_i ( bank_req[b]  ),
      .bank_rsp_o ( bank_rsp[b]  ),
      .mem_req_o  ( mem_req_o[b] ),
      .mem_rsp_i  ( mem_rsp_i[b] ),
      .err_o      ( bank_err[b]  )
    );
  end

  ecc_err_counters i_ecc_err_counters (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .err_i     ( bank_err  ),
    .reg_req_i ( reg_req_i ),
    .reg_rsp_o ( reg_rsp_o )
  );

endmodule

// File: verification/tb_clock_gen.sv
// Clock and reset source of the testbench
// 100 ns clock, active low reset held for a number of cycles

`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int unsigned HALF_NS    = 50,  // Half of the 100 ns period
  parameter int unsigned RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin : proc_clk
    clk_o = 1'b0;
    forever #(HALF_NS) clk_o = ~clk_o;
  end

  initial begin : proc_rst
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);  // Release between active edges
    rst_no = 1'b1;
  end

endmodule

// File: verification/tb_ecc_intc.sv
// Testbench of the ECC memory interconnect
// Memory bank model with bit flip injection
// SECDED reference functions, read response checker, watchdog
// Tests: read back, single and double flips, round robin, parallel banks

`timescale 1ns/100ps
`include "ecc_intc_macros.svh"

module tb_ecc_intc;

  import ecc_intc_pkg::*;

  localparam int N_WORDS  = 16;  // Random words of test 1
  localparam int N_FLIP   = 8;   // Corrupted reads per flip test
  localparam int N_RR     = 16;  // Contention cycles on one bank
  localparam int WAIT_MAX = 20;  // Cycles allowed per handshake
  localparam int RST_CYC  = 10;
  localparam int N_TXN    = 2 * N_WORDS + 4 * N_FLIP + N_RR + 2 * `ECC_N_MEM + 12;

  logic                        clk_i;
  logic                        rst_ni;
  init_req_t [`ECC_N_INIT-1:0] init_req;
  init_rsp_t [`ECC_N_INIT-1:0] init_rsp;
  mem_req_t  [`ECC_N_MEM-1:0]  mem_req;
  mem_rsp_t  [`ECC_N_MEM-1:0]  mem_rsp = '0;
  reg_req_t                    reg_req;
  reg_rsp_t                    reg_rsp;

  logic [`ECC_CODE_W-1:0] mem [`ECC_N_MEM][2**`ECC_ROW_W];  // Stored codewords
  logic [`ECC_DATA_W-1:0] golden [2**`ECC_ADDR_W];           // Last data per address
  logic [`ECC_DATA_W-1:0] exp_next [`ECC_N_INIT];            // Expected data of driven read
  logic [`ECC_DATA_W-1:0] exp_q [`ECC_N_INIT];
  logic [`ECC_N_INIT-1:0] pend_q = '0;                        // Read granted at last edge
  logic [`ECC_ADDR_W-1:0] addrs [N_WORDS];
  int                     seed;
  int                     errors;
  int                     checks;
  int                     bad_tests;
  int                     corr_exp;
  int                     uncorr_exp;

  tb_clock_gen #(.HALF_NS(50), .RST_CYCLES(RST_CYC)) i_clock_gen (
    .clk_o  ( clk_i  ),
    .rst_no ( rst_ni )
  );

  ecc_intc_top UUT (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .init_req_i ( init_req ),
    .init_rsp_o ( init_rsp ),
    .mem_req_o  ( mem_req  ),
    .mem_rsp_i  ( mem_rsp  ),
    .reg_req_i  ( reg_req  ),
    .reg_rsp_o  ( reg_rsp  )
  );

  // Hamming position k+1 in bit k, checks at powers of two, bit 38 even parity
  function automatic logic [`ECC_CODE_W-1:0] ref_encode(input logic [`ECC_DATA_W-1:0] data);
    logic [`ECC_CODE_W-1:0] cw;
    int                     d;
    cw = '0;
    d  = 0;
    for (int pos = 1; pos < `ECC_CODE_W; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        cw[pos-1] = data[d];
        d++;
      end
    end
    for (int p = 0; p < `ECC_PAR_W - 1; p++) begin
      for (int pos = 1; pos < `ECC_CODE_W; pos++) begin
        if (pos[p] && (pos != (1 << p))) begin
          cw[(1 << p) - 1] = cw[(1 << p) - 1] ^ cw[pos-1];
        end
      end
    end
    cw[`ECC_CODE_W-1] = ^cw[`ECC_CODE_W-2:0];
    return cw;
  endfunction

  function automatic logic [`ECC_DATA_W-1:0] ref_data_bits(input logic [`ECC_CODE_W-1:0] cw);
    logic [`ECC_DATA_W-1:0] data;
    int                     d;
    data = '0;
    d    = 0;
    for (int pos = 1; pos < `ECC_CODE_W; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        data[d] = cw[pos-1];
        d++;
      end
    end
    return data;
  endfunction

  // Original word up to one flip, raw data bits for two
  function automatic logic [`ECC_DATA_W-1:0] ref_read(input logic [`ECC_CODE_W-1:0] cw,
                                                      input logic [`ECC_DATA_W-1:0] orig,
                                                      input int nflips);
    if (nflips < 2) begin
      return orig;
    end
    return ref_data_bits(cw);
  endfunction

  function automatic logic [`ECC_DATA_W-1:0] fill_word(input logic [`ECC_ADDR_W-1:0] a);
    return {a, ~a, 8'hC3};  // Unique per word address
  endfunction

  task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("%s at %0d ns", msg, $time);
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("Test %s: ok", name);
    end else begin
      bad_tests++;
      $display("Test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  // Always ready, read codeword valid after the request edge
  always @(posedge clk_i) begin : proc_mem_model
    for (int b = 0; b < `ECC_N_MEM; b++) begin
      if (mem_req[b].req && mem_req[b].we) begin
        mem[b][mem_req[b].row] = mem_req[b].wcode;
      end else if (mem_req[b].req) begin
        mem_rsp[b].rcode <= mem[b][mem_req[b].row];
      end
    end
  end

  // Every granted read answers on the next edge with the expected word
  always @(posedge clk_i) begin : proc_rsp_check
    if (rst_ni) begin
      for (int i = 0; i < `ECC_N_INIT; i++) begin
        if (init_rsp[i].r_valid && !pend_q[i]) begin
          report_problem($sformatf("Read response on initiator %0d without a read", i));
        end else if (init_rsp[i].r_valid) begin
          check_eq($sformatf("initiator %0d read data", i),
                   64'(init_rsp[i].r_data), 64'(exp_q[i]));
        end else if (pend_q[i]) begin
          report_problem($sformatf("Missing read response on initiator %0d", i));
        end
        pend_q[i] <= init_rsp[i].gnt && init_req[i].req && init_req[i].wen;
        exp_q[i]  <= exp_next[i];
      end
    end
  end

  initial begin : proc_watchdog
    repeat (N_TXN * 20 + RST_CYC) @(posedge clk_i);
    $display("Timeout: tests did not finish within %0d cycles", N_TXN * 20 + RST_CYC);
    $display("sim failed");
    $finish;
  end

  task automatic access(input int port, input logic rd, input logic [`ECC_ADDR_W-1:0] addr,
                        input logic [`ECC_DATA_W-1:0] wdata,
                        input logic [`ECC_DATA_W-1:0] exp_rd);
    int n;
    @(negedge clk_i);
    init_req[port] = '{req: 1'b1, wen: rd, addr: addr, wdata: wdata};
    exp_next[port] = exp_rd;
    n = 0;
    @(posedge clk_i);
    while (!init_rsp[port].gnt && n < WAIT_MAX) begin  // Hold until granted
      n++;
      @(posedge clk_i);
    end
    if (!init_rsp[port].gnt) begin
      report_problem($sformatf("Initiator %0d was never granted", port));
    end
    @(negedge clk_i);
    init_req[port].req = 1'b0;
    if (rd) begin
      @(posedge clk_i);  // Response edge
    end else begin
      golden[addr] = wdata;
    end
  endtask

  task automatic reg_read(input logic sel, output logic [`ECC_CNT_W-1:0] val);
    int n;
    @(negedge clk_i);
    reg_req = '{valid: 1'b1, write: 1'b0, sel: sel};
    @(posedge clk_i);
    @(negedge clk_i);
    reg_req = '0;
    n = 0;
    while (!reg_rsp.valid && n < WAIT_MAX) begin
      n++;
      @(negedge clk_i);
    end
    if (!reg_rsp.valid) begin
      report_problem("Register read got no response");
    end
    val = reg_rsp.rdata;
  endtask

  task automatic reg_clear(input logic sel);
    @(negedge clk_i);
    reg_req = '{valid: 1'b1, write: 1'b1, sel: sel};
    @(negedge clk_i);
    reg_req = '0;
  endtask

  task automatic check_counters();
    logic [`ECC_CNT_W-1:0] v;
    reg_read(1'b0, v);
    check_eq("correctable counter", 64'(v), 64'(corr_exp));
    reg_read(1'b1, v);
    check_eq("uncorrectable counter", 64'(v), 64'(uncorr_exp));
  endtask

  task automatic inject_flips(input logic [`ECC_ADDR_W-1:0] addr, input int n,
                              output logic [`ECC_CODE_W-1:0] code);
    int p1;
    int p2;
    p1 = int'($unsigned($random(seed)) % `ECC_CODE_W);
    p2 = p1;
    while (n == 2 && p2 == p1) begin  // Two distinct bits
      p2 = int'($unsigned($random(seed)) % `ECC_CODE_W);
    end
    code     = mem[addr[1:0]][addr[11:2]];
    code[p1] = !code[p1];
    if (n == 2) begin
      code[p2] = !code[p2];
    end
    mem[addr[1:0]][addr[11:2]] = code;
  endtask

  task automatic run_flip_test(input int nflip);
    logic [`ECC_CODE_W-1:0] code;
    logic [`ECC_ADDR_W-1:0] a;
    for (int k = 0; k < N_FLIP; k++) begin
      a = addrs[k];
      inject_flips(a, nflip, code);
      access(k % 4, 1'b1, a, '0, ref_read(code, golden[a], nflip));
      access(k % 4, 1'b0, a, golden[a], '0);  // Restore a clean codeword
      if (nflip == 1) begin
        corr_exp++;
      end else begin
        uncorr_exp++;
      end
    end
    repeat (2) @(posedge clk_i);
    check_counters();
  endtask

  initial begin : proc_main
    logic [`ECC_N_INIT-1:0] gnts;
    logic [`ECC_ADDR_W-1:0] a;
    int                     wins [`ECC_N_INIT];
    int                     start;
    seed       = 24362;
    errors     = 0;
    checks     = 0;
    bad_tests  = 0;
    corr_exp   = 0;
    uncorr_exp = 0;
    init_req   = '0;
    reg_req    = '0;
    for (int i = 0; i < `ECC_N_INIT; i++) begin
      exp_next[i] = '0;
    end
    for (int i = 0; i < 2**`ECC_ADDR_W; i++) begin  // Clean contents everywhere
      a                    = `ECC_ADDR_W'(i);
      golden[a]            = fill_word(a);
      mem[a[1:0]][a[11:2]] = ref_encode(golden[a]);
    end
    wait (rst_ni === 1'b1);

    start = errors;
    for (int k = 0; k < N_WORDS; k++) begin
      addrs[k] = `ECC_ADDR_W'($random(seed));
      access(k % 4, 1'b0, addrs[k], $random(seed), '0);
    end
    for (int k = 0; k < N_WORDS; k++) begin
      a = addrs[k];
      access((k + 1) % 4, 1'b1, a, '0, golden[a]);
      check_eq("stored codeword", 64'(mem[a[1:0]][a[11:2]]), 64'(ref_encode(golden[a])));
    end
    check_counters();
    report_test("1 write and read back", start);

    start = errors;
    run_flip_test(1);
    report_test("2 single-bit correction", start);

    start = errors;
    run_flip_test(2);
    report_test("3 double-bit detection", start);

    start = errors;
    @(negedge clk_i);
    for (int i = 0; i < `ECC_N_INIT; i++) begin  // All on bank 0
      a           = {10'($random(seed)), 2'b00};
      init_req[i] = '{req: 1'b1, wen: 1'b1, addr: a, wdata: '0};
      exp_next[i] = golden[a];
      wins[i]     = 0;
    end
    for (int c = 0; c < N_RR; c++) begin
      @(posedge clk_i);
      for (int i = 0; i < `ECC_N_INIT; i++) begin
        gnts[i] = init_rsp[i].gnt;
        wins[i] += int'(init_rsp[i].gnt);
      end
      check_eq("grants per cycle on bank 0", 64'($countones(gnts)), 64'd1);
      if (c % 4 == 3) begin
        for (int i = 0; i < `ECC_N_INIT; i++) begin
          check_eq($sformatf("grants of initiator %0d in 4 cycles", i), 64'(wins[i]), 64'd1);
          wins[i] = 0;
        end
      end
    end
    @(negedge clk_i);
    init_req = '0;
    @(posedge clk_i);  // Last response
    report_test("4 round-robin fairness", start);

    start = errors;
    @(negedge clk_i);
    for (int i = 0; i < `ECC_N_INIT; i++) begin  // One bank per initiator
      a           = {10'($random(seed)), 2'(i + 1)};
      init_req[i] = '{req: 1'b1, wen: 1'b1, addr: a, wdata: '0};
      exp_next[i] = golden[a];
    end
    @(posedge clk_i);
    for (int i = 0; i < `ECC_N_INIT; i++) begin
      gnts[i] = init_rsp[i].gnt;
    end
    check_eq("grants to four banks", 64'(gnts), 64'hF);
    @(negedge clk_i);
    init_req = '0;
    @(posedge clk_i);
    reg_clear(1'b0);
    reg_clear(1'b1);
    corr_exp   = 0;
    uncorr_exp = 0;
    check_counters();
    report_test("5 parallel banks and counter clear", start);

    $display("Done: 5 tests, %0d with errors, %0d checks, %0d errors",
             bad_tests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: ecc_intc_top.f
+incdir+source
source/ecc_intc_pkg.sv
source/bank_xbar.sv
source/secded_bank_port.sv
source/ecc_err_counters.sv
source/ecc_intc_top.sv
verification/tb_clock_gen.sv
verification/tb_ecc_intc.sv

// File: run_sim.sh
#!/bin/sh
# Builds the ECC interconnect testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f ecc_intc_top.f \
  --top-module tb_ecc_intc \
  -o sim_ecc_intc

out=$(./obj_dir/sim_ecc_intc)
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
